// ==== source/median_pkg.sv ====
`default_nettype none

package median_pkg;

    // one grey level
    typedef logic [7:0] pixel_t;

    // vertical slice of the neighbourhood, index 0 is the oldest row
    typedef pixel_t [4:0] column_t;

    // full 5x5 neighbourhood, index 0 is the oldest column
    typedef column_t [4:0] window_t;

    // sort5 latency, in cycles
    localparam int SORT5_LAT = 2;

    // median_calc latency from win_valid to median valid
    localparam int MEDIAN_LAT = 12;

endpackage

`default_nettype wire

// ==== source/median_if.sv ====
`default_nettype none

// one column of pixels from the line buffer
interface column_if import median_pkg::*; ();

    column_t col;
    logic    col_valid;
    logic    col_sof;

    modport src (
        output col,
        output col_valid,
        output col_sof
    );

    modport dst (
        input col,
        input col_valid,
        input col_sof
    );

endinterface

// complete 5x5 window for the median stage
interface window_if import median_pkg::*; ();

    window_t win;
    logic    win_valid;

    modport src (
        output win,
        output win_valid
    );

    modport dst (
        input win,
        input win_valid
    );

endinterface

`default_nettype wire

// ==== source/line_buffer.sv ====
`default_nettype none

module line_buffer import median_pkg::*; #(
    parameter int IMG_W = 16
) (
    input  logic   clk,
    input  logic   rst,
    input  pixel_t pix_i,
    input  logic   pix_valid_i,
    input  logic   sof_i,
    column_if.src  col_o
);

    localparam int PTR_W = $clog2(IMG_W);

    // memory k returns the pixel k+1 rows above
    pixel_t           row_mem [4][IMG_W];
    logic [PTR_W-1:0] wr_ptr;

    column_t col_d;
    column_t col_q;
    logic    col_valid_q;
    logic    col_sof_q;

    always_comb begin
        col_d[4] = pix_i;
        for (int k = 0; k < 4; k++) begin
            col_d[3-k] = row_mem[k][wr_ptr];
        end
    end

    // chained delay lines, read before write at the same address
    always_ff @(posedge clk) begin
        if (pix_valid_i) begin
            row_mem[0][wr_ptr] <= pix_i;
            for (int k = 1; k < 4; k++) begin
                row_mem[k][wr_ptr] <= row_mem[k-1][wr_ptr];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (pix_valid_i) begin
            if (wr_ptr == PTR_W'(IMG_W - 1)) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            col_q       <= '0;
            col_valid_q <= 1'b0;
            col_sof_q   <= 1'b0;
        end else begin
            col_valid_q <= pix_valid_i;
            col_sof_q   <= sof_i;
            if (pix_valid_i) begin
                col_q <= col_d;
            end
        end
    end

    assign col_o.col       = col_q;
    assign col_o.col_valid = col_valid_q;
    assign col_o.col_sof   = col_sof_q;

endmodule

`default_nettype wire

// ==== source/window_shift.sv ====
`default_nettype none

module window_shift import median_pkg::*; #(
    parameter int IMG_W = 16
) (
    input  logic  clk,
    input  logic  rst,
    column_if.dst col_i,
    window_if.src win_o
);

    localparam int COL_W = $clog2(IMG_W);

    // row index only needs to reach 4
    localparam logic [2:0] ROW_SAT = 3'd4;

    logic [COL_W-1:0] col_cnt;
    logic [COL_W-1:0] cur_col;
    logic [2:0]       row_cnt;
    logic [2:0]       cur_row;

    window_t win_q;
    logic    win_valid_q;

    // position of the incoming column, sof restarts at the origin
    always_comb begin
        cur_col = col_i.col_sof ? '0 : col_cnt;
        cur_row = col_i.col_sof ? '0 : row_cnt;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            col_cnt     <= '0;
            row_cnt     <= '0;
            win_q       <= '0;
            win_valid_q <= 1'b0;
        end else begin
            // interior only: four full columns and rows behind this one
            win_valid_q <= col_i.col_valid
                           && (cur_col >= COL_W'(4))
                           && (cur_row == ROW_SAT);
            if (col_i.col_valid) begin
                win_q <= {col_i.col, win_q[4:1]};
                if (cur_col == COL_W'(IMG_W - 1)) begin
                    col_cnt <= '0;
                    if (cur_row != ROW_SAT) begin
                        row_cnt <= cur_row + 3'd1;
                    end else begin
                        row_cnt <= cur_row;
                    end
                end else begin
                    col_cnt <= cur_col + 1'b1;
                    row_cnt <= cur_row;
                end
            end
        end
    end

    assign win_o.win       = win_q;
    assign win_o.win_valid = win_valid_q;

endmodule

`default_nettype wire

// ==== source/sort5.sv ====
`default_nettype none

module sort5 import median_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  column_t in_i,
    input  logic    valid_i,
    output column_t out_o,
    output logic    valid_o
);

    column_t net_a;
    column_t mid_q;
    column_t net_b;
    logic    mid_valid;

    function automatic column_t cmp_swap(column_t v, int lo, int hi);
        column_t r;
        r = v;
        if (v[lo] > v[hi]) begin
            r[lo] = v[hi];
            r[hi] = v[lo];
        end
        return r;
    endfunction

    // first five comparators
    always_comb begin
        net_a = cmp_swap(in_i, 0, 1);
        net_a = cmp_swap(net_a, 3, 4);
        net_a = cmp_swap(net_a, 2, 4);
        net_a = cmp_swap(net_a, 2, 3);
        net_a = cmp_swap(net_a, 1, 4);
    end

    // remaining four
    always_comb begin
        net_b = cmp_swap(mid_q, 0, 3);
        net_b = cmp_swap(net_b, 0, 2);
        net_b = cmp_swap(net_b, 1, 3);
        net_b = cmp_swap(net_b, 1, 2);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mid_q     <= '0;
            mid_valid <= 1'b0;
            out_o     <= '0;
            valid_o   <= 1'b0;
        end else begin
            mid_q     <= net_a;
            mid_valid <= valid_i;
            out_o     <= net_b;
            valid_o   <= mid_valid;
        end
    end

endmodule

`default_nettype wire

// ==== source/median_calc.sv ====
`default_nettype none

module median_calc import median_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    window_if.dst  win_i,
    output pixel_t median_o,
    output logic   median_valid_o
);

    // diagonal selection takes three cycles, anti-diagonal sort covers part of it
    localparam int ANTI_DLY = 3 - SORT5_LAT;

    window_t in_q;
    logic    in_valid;

    // rows and columns both held as window_t, outer index selects the line
    window_t row_in;
    window_t row_sorted;
    logic    row_valid;
    window_t col_in;
    logic    col_in_valid;
    window_t col_sorted;
    logic    col_valid;

    // col_q[k][j]: k is the row rank, j the rank within that column
    window_t col_q;
    logic    diag_valid;

    pixel_t lo_max3;
    pixel_t lo_last;
    pixel_t hi_min3;
    pixel_t hi_last;
    pixel_t lo_max;
    pixel_t hi_min;
    pixel_t lo_cand;
    pixel_t hi_cand;

    column_t              anti_in;
    column_t              anti_sorted;
    logic                 anti_valid;
    pixel_t               anti_q [ANTI_DLY];
    logic [ANTI_DLY-1:0]  anti_valid_q;

    pixel_t cand_lo;
    pixel_t cand_mid;
    pixel_t cand_hi;
    logic   cand_valid;

    function automatic pixel_t max2(pixel_t a, pixel_t b);
        return (a > b) ? a : b;
    endfunction

    function automatic pixel_t min2(pixel_t a, pixel_t b);
        return (a < b) ? a : b;
    endfunction

    function automatic pixel_t med3(pixel_t a, pixel_t b, pixel_t c);
        return max2(min2(a, b), min2(max2(a, b), c));
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            in_q     <= '0;
            in_valid <= 1'b0;
        end else begin
            in_q     <= win_i.win;
            in_valid <= win_i.win_valid;
        end
    end

    always_comb begin
        for (int r = 0; r < 5; r++) begin
            for (int c = 0; c < 5; c++) begin
                row_in[r][c] = in_q[c][r];
            end
        end
    end

    // row and column sorters, the first of each carries the strobe
    for (genvar g = 0; g < 5; g++) begin : g_sort
        if (g == 0) begin : g_lead
            sort5 u_row (.clk, .rst, .in_i(row_in[g]), .valid_i(in_valid),
                         .out_o(row_sorted[g]), .valid_o(row_valid));
            sort5 u_col (.clk, .rst, .in_i(col_in[g]), .valid_i(col_in_valid),
                         .out_o(col_sorted[g]), .valid_o(col_valid));
        end else begin : g_rest
            sort5 u_row (.clk, .rst, .in_i(row_in[g]), .valid_i(in_valid),
                         .out_o(row_sorted[g]), .valid_o());
            sort5 u_col (.clk, .rst, .in_i(col_in[g]), .valid_i(col_in_valid),
                         .out_o(col_sorted[g]), .valid_o());
        end
    end

    // column c gathers rank c of every sorted row
    always_ff @(posedge clk) begin
        if (rst) begin
            col_in       <= '0;
            col_in_valid <= 1'b0;
            col_q        <= '0;
            diag_valid   <= 1'b0;
        end else begin
            for (int c = 0; c < 5; c++) begin
                for (int r = 0; r < 5; r++) begin
                    col_in[c][r] <= row_sorted[r][c];
                end
            end
            col_in_valid <= row_valid;
            col_q        <= col_sorted;
            diag_valid   <= col_valid;
        end
    end

    always_comb begin
        for (int j = 0; j < 5; j++) begin
            anti_in[j] = col_q[4-j][j];
        end
    end

    sort5 u_anti (.clk, .rst, .in_i(anti_in), .valid_i(diag_valid),
                  .out_o(anti_sorted), .valid_o(anti_valid));

    // max of the diagonal below, min of the diagonal above
    always_ff @(posedge clk) begin
        if (rst) begin
            lo_max3 <= '0;
            lo_last <= '0;
            hi_min3 <= '0;
            hi_last <= '0;
            lo_max  <= '0;
            hi_min  <= '0;
            lo_cand <= '0;
            hi_cand <= '0;
        end else begin
            lo_max3 <= max2(max2(col_q[3][0], col_q[2][1]), col_q[1][2]);
            lo_last <= col_q[0][3];
            hi_min3 <= min2(min2(col_q[4][1], col_q[3][2]), col_q[2][3]);
            hi_last <= col_q[1][4];
            lo_max  <= max2(lo_max3, lo_last);
            hi_min  <= min2(hi_min3, hi_last);
            lo_cand <= lo_max;
            hi_cand <= hi_min;
        end
    end

    // align the anti-diagonal median with the other candidates
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ANTI_DLY; i++) begin
                anti_q[i] <= '0;
            end
            anti_valid_q <= '0;
        end else begin
            anti_q[0]       <= anti_sorted[2];
            anti_valid_q[0] <= anti_valid;
            for (int i = 1; i < ANTI_DLY; i++) begin
                anti_q[i]       <= anti_q[i-1];
                anti_valid_q[i] <= anti_valid_q[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cand_lo        <= '0;
            cand_mid       <= '0;
            cand_hi        <= '0;
            cand_valid     <= 1'b0;
            median_o       <= '0;
            median_valid_o <= 1'b0;
        end else begin
            cand_lo        <= lo_cand;
            cand_mid       <= anti_q[ANTI_DLY-1];
            cand_hi        <= hi_cand;
            cand_valid     <= anti_valid_q[ANTI_DLY-1];
            median_o       <= med3(cand_lo, cand_mid, cand_hi);
            median_valid_o <= cand_valid;
        end
    end

endmodule

`default_nettype wire

// ==== source/median_filter_top.sv ====
`default_nettype none

module median_filter_top import median_pkg::*; #(
    parameter int IMG_W = 16
) (
    input  logic   clk,
    input  logic   rst,
    input  pixel_t pix_i,
    input  logic   pix_valid_i,
    input  logic   sof_i,
    output pixel_t median_o,
    output logic   median_valid_o
);

    column_if col_bus ();
    window_if win_bus ();

    // four rows of history plus the live pixel
    line_buffer #(
        .IMG_W (IMG_W)
    ) u_line_buffer (
        .clk         (clk),
        .rst         (rst),
        .pix_i       (pix_i),
        .pix_valid_i (pix_valid_i),
        .sof_i       (sof_i),
        .col_o       (col_bus.src)
    );

    window_shift #(
        .IMG_W (IMG_W)
    ) u_window_shift (
        .clk   (clk),
        .rst   (rst),
        .col_i (col_bus.dst),
        .win_o (win_bus.src)
    );

    median_calc u_median_calc (
        .clk            (clk),
        .rst            (rst),
        .win_i          (win_bus.dst),
        .median_o       (median_o),
        .median_valid_o (median_valid_o)
    );

endmodule

`default_nettype wire

// ==== tb/median_filter_tb.sv ====
`default_nettype none

module median_filter_tb import median_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int IMG_W     = 16;
    localparam int ROWS      = 8;
    localparam int CLK_NS    = 20;
    localparam int RST_CYC   = 3;
    localparam int FRAME_PIX = ROWS * IMG_W;
    localparam int PART_ROWS = 5;
    localparam int PART_COLS = 7;
    localparam int PART_PIX  = PART_ROWS * IMG_W + PART_COLS;
    localparam int N_FULL    = 9;
    localparam int N_DRAIN   = 9;
    localparam int GAP_PIX   = 2 * FRAME_PIX;
    localparam int DRAIN_MAX = MEDIAN_LAT + 8;
    localparam int TOTAL_PIX = N_FULL * FRAME_PIX + PART_PIX;
    localparam int IDLE_CYC  = RST_CYC + 2 + N_DRAIN * (DRAIN_MAX + 1) + GAP_PIX;
    localparam int WATCHDOG_NS = (TOTAL_PIX + IDLE_CYC + 50) * CLK_NS;
    localparam int PER_FRAME = (ROWS - 4) * (IMG_W - 4);

    // starts low without an edge at time zero
    logic   clk = 1'b0;
    logic   rst;
    pixel_t pix_i;
    logic   pix_valid_i;
    logic   sof_i;
    pixel_t median_o;
    logic   median_valid_o;

    pixel_t frame [ROWS][IMG_W];
    pixel_t exp_q [$];
    string  test_name;
    int     out_cnt;
    int     mismatch_errs;
    int     other_errs;
    bit     first_drv_seen;
    bit     first_out_seen;
    realtime first_drv_time;
    realtime first_out_time;

    median_filter_top #(
        .IMG_W (IMG_W)
    ) i_dut (
        .clk            (clk),
        .rst            (rst),
        .pix_i          (pix_i),
        .pix_valid_i    (pix_valid_i),
        .sof_i          (sof_i),
        .median_o       (median_o),
        .median_valid_o (median_valid_o)
    );

    always #(CLK_NS / 2) clk = ~clk;

    task automatic check_pixel(string name, pixel_t exp_v, pixel_t act_v);
        if (exp_v !== act_v) begin
            $display("Mismatch %s expected %0d actual %0d", name, exp_v, act_v);
            mismatch_errs++;
        end
    endtask

    task automatic check_count(string name, int exp_v, int act_v);
        if (exp_v != act_v) begin
            $display("Mismatch %s expected %0d actual %0d", name, exp_v, act_v);
            mismatch_errs++;
        end
    endtask

    // reference median by full sort of the neighbourhood ending at (r, c)
    function automatic pixel_t window_median(int r, int c);
        pixel_t v [25];
        pixel_t t;
        int     n;
        int     j;
        n = 0;
        for (int dr = 0; dr < 5; dr++) begin
            for (int dc = 0; dc < 5; dc++) begin
                v[n] = frame[r - 4 + dr][c - 4 + dc];
                n = n + 1;
            end
        end
        for (int i = 1; i < 25; i++) begin
            t = v[i];
            j = i - 1;
            while (j >= 0 && v[j] > t) begin
                v[j + 1] = v[j];
                j = j - 1;
            end
            v[j + 1] = t;
        end
        return v[12];
    endfunction

    // mode 0 uniform, 1 random, 2 only 0, 255 and one mid level
    task automatic fill_frame(int mode);
        pixel_t level;
        pixel_t pick;
        level = pixel_t'($urandom);
        if (mode == 2) begin
            level = pixel_t'(1 + ($urandom % 254));
        end
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < IMG_W; c++) begin
                case (mode)
                    0: pick = level;
                    1: pick = pixel_t'($urandom);
                    default: begin
                        case ($urandom % 3)
                            0: pick = 8'd0;
                            1: pick = 8'd255;
                            default: pick = level;
                        endcase
                    end
                endcase
                frame[r][c] = pick;
            end
        end
    endtask

    task automatic queue_expected(int n_pix);
        for (int idx = 0; idx < n_pix; idx++) begin
            if (idx / IMG_W >= 4 && idx % IMG_W >= 4) begin
                exp_q.push_back(window_median(idx / IMG_W, idx % IMG_W));
            end
        end
    endtask

    // last pixel is left on the bus so a following frame can start mid-stream
    task automatic stream_frame(int n_pix, bit gaps);
        for (int idx = 0; idx < n_pix; idx++) begin
            @(negedge clk);
            if (gaps && ($urandom % 100) < 30) begin
                pix_valid_i = 1'b0;
                sof_i       = 1'b0;
                @(negedge clk);
            end
            pix_i       = frame[idx / IMG_W][idx % IMG_W];
            pix_valid_i = 1'b1;
            sof_i       = (idx == 0);
            if (!first_drv_seen && idx / IMG_W >= 4 && idx % IMG_W >= 4) begin
                first_drv_seen = 1'b1;
                first_drv_time = $realtime;
            end
        end
    endtask

    task automatic drain_frame(string name, int exp_cnt);
        @(negedge clk);
        pix_valid_i = 1'b0;
        sof_i       = 1'b0;
        for (int i = 0; i < DRAIN_MAX; i++) begin
            @(posedge clk);
            if (exp_q.size() == 0) begin
                break;
            end
        end
        if (exp_q.size() != 0) begin
            $display("%s: %0d expected results never came out", name, exp_q.size());
            other_errs++;
            exp_q.delete();
        end
        check_count(name, exp_cnt, out_cnt);
        out_cnt = 0;
    endtask

    task automatic run_frames(string name, int mode, int count, bit gaps);
        test_name = name;
        for (int f = 0; f < count; f++) begin
            fill_frame(mode);
            queue_expected(FRAME_PIX);
            stream_frame(FRAME_PIX, gaps);
            drain_frame(name, PER_FRAME);
        end
    endtask

    // outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        if (rst) begin
            if (median_valid_o !== 1'b0) begin
                $display("median_valid_o is high while reset is asserted");
                other_errs++;
            end
        end else if (median_valid_o === 1'b1) begin
            if (!first_out_seen) begin
                first_out_seen = 1'b1;
                first_out_time = $realtime;
            end
            if (exp_q.size() == 0) begin
                $display("%s: median strobe with no result outstanding", test_name);
                other_errs++;
            end else begin
                check_pixel(test_name, exp_q.pop_front(), median_o);
                out_cnt++;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout after %0d ns, the pipeline stopped producing results", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(1089));
        rst         = 1'b1;
        pix_i       = '0;
        pix_valid_i = 1'b0;
        sof_i       = 1'b0;
        test_name   = "reset";
        repeat (RST_CYC) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        run_frames("uniform", 0, 1, 1'b0);
        run_frames("random", 1, 3, 1'b0);
        run_frames("random_gaps", 1, 2, 1'b1);
        run_frames("extremes", 2, 2, 1'b0);

        // partial frame cut short by a new sof
        test_name = "restart";
        fill_frame(1);
        queue_expected(PART_PIX);
        stream_frame(PART_PIX, 1'b0);
        fill_frame(1);
        queue_expected(FRAME_PIX);
        stream_frame(FRAME_PIX, 1'b0);
        drain_frame("restart", (PART_ROWS - 4) * (IMG_W - 4) + PART_COLS - 4 + PER_FRAME);

        if (!first_out_seen) begin
            $display("no median output appeared during the run");
            other_errs++;
        end else begin
            check_count("first_latency", MEDIAN_LAT + 2,
                        int'(first_out_time - first_drv_time) / CLK_NS);
        end

        $display("errors: mismatches %0d, other %0d", mismatch_errs, other_errs);
        if (mismatch_errs == 0 && other_errs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
source/median_pkg.sv
source/median_if.sv
source/line_buffer.sv
source/window_shift.sv
source/sort5.sv
source/median_calc.sv
source/median_filter_top.sv
tb/median_filter_tb.sv
